// File: src/axi_mem_defines.svh
// AXI-lite memory parameters
`ifndef AXI_MEM_DEFINES_SVH
`define AXI_MEM_DEFINES_SVH

// bus widths
`define AXI_MEM_ADDR_W      32
`define AXI_MEM_DATA_W      32
`define AXI_MEM_STRB_W      4   // one bit per data byte

// 256 words, index from addr[9:2]
`define AXI_MEM_DEPTH_LOG2  8

// response delay: 0 none, 1 fixed, 2 lfsr
`define AXI_MEM_DELAY_MODE  2

// cycles used in fixed mode, 1..15
`define AXI_MEM_FIXED_DELAY 3

`endif

// File: src/axi_mem_pkg.sv
// AXI-lite memory types
`default_nettype none
`include "axi_mem_defines.svh"

package axi_mem_pkg;

	typedef logic [`AXI_MEM_ADDR_W-1:0] axi_addr_t;
	typedef logic [`AXI_MEM_DATA_W-1:0] axi_data_t;
	typedef logic [`AXI_MEM_STRB_W-1:0] axi_strb_t;
	typedef logic [1:0]                 axi_resp_t;

	localparam axi_resp_t RESP_OKAY   = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;

	typedef struct packed {
		axi_addr_t addr;
	} axi_ar_t;

	typedef struct packed {
		axi_addr_t addr;
	} axi_aw_t;

	typedef struct packed {
		axi_data_t data;
		axi_strb_t strb;
	} axi_w_t;

	typedef struct packed {
		axi_data_t data;
		axi_resp_t resp;
	} axi_r_t;

	typedef struct packed {
		axi_resp_t resp;
	} axi_b_t;

	// master to slave side of one port
	typedef struct packed {
		axi_ar_t ar;
		logic    ar_valid;
		axi_aw_t aw;
		logic    aw_valid;
		axi_w_t  w;
		logic    w_valid;
		logic    r_ready;
		logic    b_ready;
	} axi_req_t;

	// slave to master side of one port
	typedef struct packed {
		logic    ar_ready;
		logic    aw_ready;
		logic    w_ready;
		axi_r_t  r;
		logic    r_valid;
		axi_b_t  b;
		logic    b_valid;
	} axi_rsp_t;

	// all five channels of one master port
	typedef struct packed {
		axi_req_t req;
		axi_rsp_t rsp;
	} axi_port_t;

endpackage

`default_nettype wire

// File: src/lfsr4.sv
// 4-bit delay LFSR
`timescale 1ns/1ps
`default_nettype none

module lfsr4 (
	input  logic       clk,
	input  logic       rstn,
	output logic [3:0] value_o
);

	logic [3:0] lfsr_q;
	logic       feedback;

	// x^4 + x^3 + 1, period 15
	assign feedback = lfsr_q[3] ^ lfsr_q[2];

	always_ff @(posedge clk) begin
		if (!rstn) begin
			lfsr_q <= 4'b0001; // any nonzero seed
		end else begin
			lfsr_q <= {lfsr_q[2:0], feedback};
		end
	end

	assign value_o = lfsr_q; // all-zero state unreachable

endmodule

`default_nettype wire

// File: src/sram_array.sv
// Byte-strobed word memory
`timescale 1ns/1ps
`default_nettype none
`include "axi_mem_defines.svh"

module sram_array
	import axi_mem_pkg::*;
(
	input  logic                           clk,
	input  logic                           we_i,
	input  logic [`AXI_MEM_DEPTH_LOG2-1:0] waddr_i,
	input  axi_data_t                      wdata_i,
	input  axi_strb_t                      wstrb_i,
	input  logic                           re_i,
	input  logic [`AXI_MEM_DEPTH_LOG2-1:0] raddr_i,
	output axi_data_t                      rdata_o
);

	localparam int DEPTH  = 1 << `AXI_MEM_DEPTH_LOG2;
	localparam int NBYTES = `AXI_MEM_STRB_W;

	axi_data_t mem [DEPTH];

	// write port, one lane per strobe bit
	always_ff @(posedge clk) begin
		if (we_i) begin
			for (int i = 0; i < NBYTES; i++) begin
				if (wstrb_i[i]) begin
					mem[waddr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
				end
			end
		end
	end

	// registered read, held until the next re_i
	always_ff @(posedge clk) begin
		if (re_i) begin
			rdata_o <= mem[raddr_i];
		end
	end

endmodule

`default_nettype wire

// File: src/axi_sram.sv
// AXI-lite SRAM slave
`timescale 1ns/1ps
`default_nettype none
`include "axi_mem_defines.svh"

module axi_sram
	import axi_mem_pkg::*;
(
	input  logic    clk,
	input  logic    rstn,

	input  axi_ar_t ar_i,
	input  logic    ar_valid_i,
	output logic    ar_ready_o,

	input  axi_aw_t aw_i,
	input  logic    aw_valid_i,
	output logic    aw_ready_o,

	input  axi_w_t  w_i,
	input  logic    w_valid_i,
	output logic    w_ready_o,

	output axi_r_t  r_o,
	output logic    r_valid_o,
	input  logic    r_ready_i,

	output axi_b_t  b_o,
	output logic    b_valid_o,
	input  logic    b_ready_i
);

	localparam int ADDR_W     = `AXI_MEM_ADDR_W;
	localparam int IDX_W      = `AXI_MEM_DEPTH_LOG2;
	localparam int DELAY_MODE = `AXI_MEM_DELAY_MODE;

	typedef enum logic [1:0] {
		WAIT_ADDR,
		READ_RESP,
		WRITE_RESP
	} state_t;

	state_t           state_q;
	state_t           state_d;
	logic [3:0]       cnt_q;      // cycles left until response valid
	logic [3:0]       delay_val;
	logic             mem_we_q;
	logic             mem_re;
	logic             rd_take;
	logic             wr_take;
	logic             addr_ok;
	axi_addr_t        addr_q;
	axi_data_t        wdata_q;
	axi_strb_t        wstrb_q;
	axi_data_t        rdata;

	// anything above the word index is out of range
	function automatic logic in_range(input axi_addr_t addr);
		return addr[ADDR_W-1:IDX_W+2] == '0;
	endfunction

	generate
		if (DELAY_MODE == 2) begin : g_rand_delay
			logic [3:0] lfsr_val;

			lfsr4 lfsr4_inst (
				.clk     (clk),
				.rstn    (rstn),
				.value_o (lfsr_val)
			);

			assign delay_val = lfsr_val; // never zero
		end else if (DELAY_MODE == 1) begin : g_fixed_delay
			assign delay_val = 4'(`AXI_MEM_FIXED_DELAY);
		end else begin : g_no_delay
			assign delay_val = 4'd1;
		end
	endgenerate

	// aw and w are only taken together, and never alongside a read
	assign ar_ready_o = (state_q == WAIT_ADDR);
	assign aw_ready_o = (state_q == WAIT_ADDR) && !ar_valid_i && w_valid_i;
	assign w_ready_o  = (state_q == WAIT_ADDR) && !ar_valid_i && aw_valid_i;

	assign rd_take = ar_valid_i && ar_ready_o;
	assign wr_take = aw_valid_i && aw_ready_o && w_valid_i && w_ready_o;
	assign addr_ok = in_range(addr_q);

	always_comb begin
		state_d = state_q;
		case (state_q)
			WAIT_ADDR: begin
				if (rd_take) begin
					state_d = READ_RESP;
				end else if (wr_take) begin
					state_d = WRITE_RESP;
				end
			end
			READ_RESP: begin
				if (r_valid_o && r_ready_i) begin
					state_d = WAIT_ADDR;
				end
			end
			WRITE_RESP: begin
				if (b_valid_o && b_ready_i) begin
					state_d = WAIT_ADDR;
				end
			end
			default: state_d = WAIT_ADDR;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q  <= WAIT_ADDR;
			cnt_q    <= 4'd0;
			mem_we_q <= 1'b0;
		end else begin
			state_q  <= state_d;
			mem_we_q <= wr_take && in_range(aw_i.addr); // commit one cycle later
			if (rd_take || wr_take) begin
				cnt_q <= delay_val;
			end else if (cnt_q != 4'd0) begin
				cnt_q <= cnt_q - 4'd1;
			end
		end
	end

	// accepted request payload
	always_ff @(posedge clk) begin
		if (rd_take) begin
			addr_q <= ar_i.addr;
		end else if (wr_take) begin
			addr_q  <= aw_i.addr;
			wdata_q <= w_i.data;
			wstrb_q <= w_i.strb;
		end
	end

	// read one cycle ahead so rdata lands as r_valid rises
	assign mem_re = (state_q == READ_RESP) && (cnt_q == 4'd1);

	sram_array sram_array_inst (
		.clk     (clk),
		.we_i    (mem_we_q),
		.waddr_i (addr_q[IDX_W+1:2]),
		.wdata_i (wdata_q),
		.wstrb_i (wstrb_q),
		.re_i    (mem_re),
		.raddr_i (addr_q[IDX_W+1:2]),
		.rdata_o (rdata)
	);

	assign r_valid_o = (state_q == READ_RESP) && (cnt_q == 4'd0);
	assign r_o.data  = addr_ok ? rdata : '0;
	assign r_o.resp  = addr_ok ? RESP_OKAY : RESP_SLVERR;

	assign b_valid_o = (state_q == WRITE_RESP) && (cnt_q == 4'd0);
	assign b_o.resp  = addr_ok ? RESP_OKAY : RESP_SLVERR;

	a_one_rsp: assert property (@(posedge clk) disable iff (!rstn)
		!(r_valid_o && b_valid_o));

	// payload must hold under back-pressure
	a_r_hold: assert property (@(posedge clk) disable iff (!rstn)
		r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o));

	a_b_hold: assert property (@(posedge clk) disable iff (!rstn)
		b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_o));

endmodule

`default_nettype wire

// File: src/axi_arbiter.sv
// Two-port round-robin AXI-lite arbiter
`timescale 1ns/1ps
`default_nettype none

module axi_arbiter
	import axi_mem_pkg::*;
(
	input  logic           clk,
	input  logic           rstn,

	input  axi_req_t [1:0] m_req_i,
	output axi_rsp_t [1:0] m_rsp_o,

	output axi_ar_t        s_ar_o,
	output logic           s_ar_valid_o,
	input  logic           s_ar_ready_i,

	output axi_aw_t        s_aw_o,
	output logic           s_aw_valid_o,
	input  logic           s_aw_ready_i,

	output axi_w_t         s_w_o,
	output logic           s_w_valid_o,
	input  logic           s_w_ready_i,

	input  axi_r_t         s_r_i,
	input  logic           s_r_valid_i,
	output logic           s_r_ready_o,

	input  axi_b_t         s_b_i,
	input  logic           s_b_valid_i,
	output logic           s_b_ready_o
);

	localparam int NPORT = 2;

	logic [NPORT-1:0] req;
	logic [NPORT-1:0] sel;
	logic             busy_q;
	logic             grant_q;  // index of the port being served
	logic             last_q;   // round-robin pointer
	logic             pick;
	logic             done;
	axi_req_t         greq;

	genvar i;

	generate
		for (i = 0; i < NPORT; i++) begin : g_req
			// a write only counts once aw and w are both up
			assign req[i] = m_req_i[i].ar_valid ||
				(m_req_i[i].aw_valid && m_req_i[i].w_valid);
		end
	endgenerate

	// next requester after the last one served
	assign pick = req[!last_q] ? !last_q : last_q;

	// transaction finishes on the response handshake
	assign done = (s_r_valid_i && s_r_ready_o) || (s_b_valid_i && s_b_ready_o);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			busy_q  <= 1'b0;
			grant_q <= 1'b0;
			last_q  <= 1'b1; // port 0 goes first
		end else if (!busy_q) begin
			if (|req) begin
				busy_q  <= 1'b1;
				grant_q <= pick;
				last_q  <= pick;
			end
		end else if (done) begin
			busy_q <= 1'b0;
		end
	end

	assign greq = m_req_i[grant_q];

	// slave side sees only the granted port
	assign s_ar_o       = greq.ar;
	assign s_ar_valid_o = busy_q && greq.ar_valid;
	assign s_aw_o       = greq.aw;
	assign s_aw_valid_o = busy_q && greq.aw_valid;
	assign s_w_o        = greq.w;
	assign s_w_valid_o  = busy_q && greq.w_valid;
	assign s_r_ready_o  = busy_q && greq.r_ready;
	assign s_b_ready_o  = busy_q && greq.b_ready;

	generate
		for (i = 0; i < NPORT; i++) begin : g_rsp
			assign sel[i] = busy_q && (grant_q == i);

			assign m_rsp_o[i].ar_ready = sel[i] && s_ar_ready_i;
			assign m_rsp_o[i].aw_ready = sel[i] && s_aw_ready_i;
			assign m_rsp_o[i].w_ready  = sel[i] && s_w_ready_i;
			assign m_rsp_o[i].r        = s_r_i;  // qualified by r_valid
			assign m_rsp_o[i].r_valid  = sel[i] && s_r_valid_i;
			assign m_rsp_o[i].b        = s_b_i;
			assign m_rsp_o[i].b_valid  = sel[i] && s_b_valid_i;

			a_quiet: assert property (@(posedge clk) disable iff (!rstn)
				!sel[i] |-> !(m_rsp_o[i].ar_ready || m_rsp_o[i].aw_ready ||
				m_rsp_o[i].w_ready || m_rsp_o[i].r_valid || m_rsp_o[i].b_valid));
		end
	endgenerate

	// the owner stays fixed for the whole transaction
	a_grant_hold: assert property (@(posedge clk) disable iff (!rstn)
		busy_q |=> $stable(grant_q));

endmodule

`default_nettype wire

// File: src/axi_mem_top.sv
// Shared SRAM with fetch and data ports
`timescale 1ns/1ps
`default_nettype none

module axi_mem_top
	import axi_mem_pkg::*;
(
	input  logic    clk,
	input  logic    rstn,

	// instruction fetch port
	input  axi_ar_t if_ar_i,
	input  logic    if_ar_valid_i,
	output logic    if_ar_ready_o,
	input  axi_aw_t if_aw_i,
	input  logic    if_aw_valid_i,
	output logic    if_aw_ready_o,
	input  axi_w_t  if_w_i,
	input  logic    if_w_valid_i,
	output logic    if_w_ready_o,
	output axi_r_t  if_r_o,
	output logic    if_r_valid_o,
	input  logic    if_r_ready_i,
	output axi_b_t  if_b_o,
	output logic    if_b_valid_o,
	input  logic    if_b_ready_i,

	// load/store port
	input  axi_ar_t ls_ar_i,
	input  logic    ls_ar_valid_i,
	output logic    ls_ar_ready_o,
	input  axi_aw_t ls_aw_i,
	input  logic    ls_aw_valid_i,
	output logic    ls_aw_ready_o,
	input  axi_w_t  ls_w_i,
	input  logic    ls_w_valid_i,
	output logic    ls_w_ready_o,
	output axi_r_t  ls_r_o,
	output logic    ls_r_valid_o,
	input  logic    ls_r_ready_i,
	output axi_b_t  ls_b_o,
	output logic    ls_b_valid_o,
	input  logic    ls_b_ready_i
);

	wire axi_port_t [1:0] port_bus;  // 0 fetch, 1 load/store

	axi_ar_t s_ar;
	axi_aw_t s_aw;
	axi_w_t  s_w;
	axi_r_t  s_r;
	axi_b_t  s_b;
	logic    s_ar_valid;
	logic    s_ar_ready;
	logic    s_aw_valid;
	logic    s_aw_ready;
	logic    s_w_valid;
	logic    s_w_ready;
	logic    s_r_valid;
	logic    s_r_ready;
	logic    s_b_valid;
	logic    s_b_ready;

	assign port_bus[0].req = '{ar: if_ar_i, ar_valid: if_ar_valid_i,
		aw: if_aw_i, aw_valid: if_aw_valid_i, w: if_w_i, w_valid: if_w_valid_i,
		r_ready: if_r_ready_i, b_ready: if_b_ready_i};

	assign port_bus[1].req = '{ar: ls_ar_i, ar_valid: ls_ar_valid_i,
		aw: ls_aw_i, aw_valid: ls_aw_valid_i, w: ls_w_i, w_valid: ls_w_valid_i,
		r_ready: ls_r_ready_i, b_ready: ls_b_ready_i};

	assign if_ar_ready_o = port_bus[0].rsp.ar_ready;
	assign if_aw_ready_o = port_bus[0].rsp.aw_ready;
	assign if_w_ready_o  = port_bus[0].rsp.w_ready;
	assign if_r_o        = port_bus[0].rsp.r;
	assign if_r_valid_o  = port_bus[0].rsp.r_valid;
	assign if_b_o        = port_bus[0].rsp.b;
	assign if_b_valid_o  = port_bus[0].rsp.b_valid;

	assign ls_ar_ready_o = port_bus[1].rsp.ar_ready;
	assign ls_aw_ready_o = port_bus[1].rsp.aw_ready;
	assign ls_w_ready_o  = port_bus[1].rsp.w_ready;
	assign ls_r_o        = port_bus[1].rsp.r;
	assign ls_r_valid_o  = port_bus[1].rsp.r_valid;
	assign ls_b_o        = port_bus[1].rsp.b;
	assign ls_b_valid_o  = port_bus[1].rsp.b_valid;

	axi_arbiter axi_arbiter_inst (
		.clk          (clk),
		.rstn         (rstn),
		.m_req_i      ({port_bus[1].req, port_bus[0].req}),
		.m_rsp_o      ({port_bus[1].rsp, port_bus[0].rsp}),
		.s_ar_o       (s_ar),
		.s_ar_valid_o (s_ar_valid),
		.s_ar_ready_i (s_ar_ready),
		.s_aw_o       (s_aw),
		.s_aw_valid_o (s_aw_valid),
		.s_aw_ready_i (s_aw_ready),
		.s_w_o        (s_w),
		.s_w_valid_o  (s_w_valid),
		.s_w_ready_i  (s_w_ready),
		.s_r_i        (s_r),
		.s_r_valid_i  (s_r_valid),
		.s_r_ready_o  (s_r_ready),
		.s_b_i        (s_b),
		.s_b_valid_i  (s_b_valid),
		.s_b_ready_o  (s_b_ready)
	);

	axi_sram axi_sram_inst (
		.clk        (clk),
		.rstn       (rstn),
		.ar_i       (s_ar),
		.ar_valid_i (s_ar_valid),
		.ar_ready_o (s_ar_ready),
		.aw_i       (s_aw),
		.aw_valid_i (s_aw_valid),
		.aw_ready_o (s_aw_ready),
		.w_i        (s_w),
		.w_valid_i  (s_w_valid),
		.w_ready_o  (s_w_ready),
		.r_o        (s_r),
		.r_valid_o  (s_r_valid),
		.r_ready_i  (s_r_ready),
		.b_o        (s_b),
		.b_valid_o  (s_b_valid),
		.b_ready_i  (s_b_ready)
	);

endmodule

`default_nettype wire

// File: tb/tb_axi_mem_top.sv
// Shared SRAM testbench
`timescale 1ns/1ps
`default_nettype none
`include "axi_mem_defines.svh"

module tb_axi_mem_top
	import axi_mem_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int IDX_W      = `AXI_MEM_DEPTH_LOG2;
	localparam int DEPTH      = 1 << IDX_W;
	localparam int MAX_DELAY  = 15;
	localparam int N_TXN      = 456; // fill 256, then 64 + 32 + 24 + 64 + 16
	localparam longint WATCHDOG_NS = longint'(N_TXN) * 40 * MAX_DELAY * CLK_PERIOD;

	logic clk;
	logic rstn;

	// master side, index 0 fetch and 1 load/store
	axi_ar_t ar [2];
	logic    ar_valid [2];
	axi_aw_t aw [2];
	logic    aw_valid [2];
	axi_w_t  w [2];
	logic    w_valid [2];
	logic    r_ready [2];
	logic    b_ready [2];

	logic [1:0]         ar_ready;
	logic [1:0]         aw_ready;
	logic [1:0]         w_ready;
	axi_r_t [1:0]       r_rsp;
	logic [1:0]         r_valid;
	axi_b_t [1:0]       b_rsp;
	logic [1:0]         b_valid;

	// handshakes seen at the last rising edge
	logic [1:0] ar_done;
	logic [1:0] aw_done;
	logic [1:0] r_done;
	logic [1:0] b_done;

	axi_data_t ref_mem [DEPTH];
	axi_r_t    exp_r_q [2][$];
	axi_b_t    exp_b_q [2][$];
	int        waits [2];       // other-port transactions seen while pending
	string     test_name;
	int        seed = 27;

	axi_mem_top axi_mem_top_inst (
		.clk           (clk),
		.rstn          (rstn),
		.if_ar_i       (ar[0]),
		.if_ar_valid_i (ar_valid[0]),
		.if_ar_ready_o (ar_ready[0]),
		.if_aw_i       (aw[0]),
		.if_aw_valid_i (aw_valid[0]),
		.if_aw_ready_o (aw_ready[0]),
		.if_w_i        (w[0]),
		.if_w_valid_i  (w_valid[0]),
		.if_w_ready_o  (w_ready[0]),
		.if_r_o        (r_rsp[0]),
		.if_r_valid_o  (r_valid[0]),
		.if_r_ready_i  (r_ready[0]),
		.if_b_o        (b_rsp[0]),
		.if_b_valid_o  (b_valid[0]),
		.if_b_ready_i  (b_ready[0]),
		.ls_ar_i       (ar[1]),
		.ls_ar_valid_i (ar_valid[1]),
		.ls_ar_ready_o (ar_ready[1]),
		.ls_aw_i       (aw[1]),
		.ls_aw_valid_i (aw_valid[1]),
		.ls_aw_ready_o (aw_ready[1]),
		.ls_w_i        (w[1]),
		.ls_w_valid_i  (w_valid[1]),
		.ls_w_ready_o  (w_ready[1]),
		.ls_r_o        (r_rsp[1]),
		.ls_r_valid_o  (r_valid[1]),
		.ls_r_ready_i  (r_ready[1]),
		.ls_b_o        (b_rsp[1]),
		.ls_b_valid_o  (b_valid[1]),
		.ls_b_ready_i  (b_ready[1])
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	function automatic logic addr_in_range(input axi_addr_t addr);
		return addr[`AXI_MEM_ADDR_W-1:IDX_W+2] == '0;
	endfunction

	function automatic axi_addr_t word_addr(input int idx);
		return axi_addr_t'(idx) << 2;
	endfunction

	// every byte depends on the word index
	function automatic axi_data_t fill_word(input int idx);
		return {8'(idx), 8'(~idx), 8'(idx * 3), 8'(idx ^ 8'h5a)};
	endfunction

	function automatic axi_data_t merge_bytes(input axi_data_t old, input axi_data_t data,
		input axi_strb_t strb);
		axi_data_t res;
		res = old;
		for (int i = 0; i < `AXI_MEM_STRB_W; i++) begin
			if (strb[i]) res[i*8 +: 8] = data[i*8 +: 8];
		end
		return res;
	endfunction

	always @(posedge clk) begin
		for (int p = 0; p < 2; p++) begin
			ar_done[p] <= ar_valid[p] && ar_ready[p];
			aw_done[p] <= aw_valid[p] && aw_ready[p];
			r_done[p]  <= r_valid[p] && r_ready[p];
			b_done[p]  <= b_valid[p] && b_ready[p];
		end
	end

	task automatic check_idle();
		a_idle: assert (ar_ready == '0 && aw_ready == '0 && w_ready == '0 &&
			r_valid == '0 && b_valid == '0)
			else abort_run("a ready or response valid output is high before any request");
	endtask

	task automatic check_read_response(input int p, input axi_r_t got);
		axi_r_t exp;
		if (exp_r_q[p].size() == 0) begin
			abort_run($sformatf("port %0d gave a read response that was never requested", p));
		end else begin
			exp = exp_r_q[p].pop_front();
			a_r_match: assert (got.resp == exp.resp &&
				(exp.resp != RESP_OKAY || got.data == exp.data))
				else abort_run($sformatf("error: %s port %0d read expected %h actual %h",
					test_name, p, exp, got));
		end
	endtask

	task automatic check_write_response(input int p, input axi_b_t got);
		axi_b_t exp;
		if (exp_b_q[p].size() == 0) begin
			abort_run($sformatf("port %0d gave a write response that was never requested", p));
		end else begin
			exp = exp_b_q[p].pop_front();
			a_b_match: assert (got.resp == exp.resp)
				else abort_run($sformatf("error: %s port %0d write expected %h actual %h",
					test_name, p, exp, got));
		end
	endtask

	// a waiting port sees at most one transaction of the other port
	task automatic count_waits(input int p);
		logic pending;
		logic served;
		logic other_done;
		pending    = ar_valid[p] || (aw_valid[p] && w_valid[p]);
		served     = (ar_valid[p] && ar_ready[p]) || (aw_valid[p] && aw_ready[p]);
		other_done = (r_valid[1-p] && r_ready[1-p]) || (b_valid[1-p] && b_ready[1-p]);
		if (!pending || served) waits[p] = 0;
		else if (other_done) waits[p] = waits[p] + 1;
		a_fair: assert (waits[p] <= 1)
			else abort_run($sformatf("error: %s port %0d grants waited expected 1 actual %0d",
				test_name, p, waits[p]));
	endtask

	always @(posedge clk) begin
		if (rstn) begin
			for (int p = 0; p < 2; p++) begin
				if (r_valid[p] && r_ready[p]) check_read_response(p, r_rsp[p]);
				if (b_valid[p] && b_ready[p]) check_write_response(p, b_rsp[p]);
				count_waits(p);
			end
		end
	end

	generate
		for (genvar g = 0; g < 2; g++) begin : g_hold
			a_r_hold: assert property (@(posedge clk) disable iff (!rstn)
				r_valid[g] && !r_ready[g] |=> r_valid[g] && $stable(r_rsp[g]))
				else abort_run("read response dropped or changed while r_ready was low");
			a_b_hold: assert property (@(posedge clk) disable iff (!rstn)
				b_valid[g] && !b_ready[g] |=> b_valid[g] && $stable(b_rsp[g]))
				else abort_run("write response dropped or changed while b_ready was low");
		end
	endgenerate

	// hold is the number of cycles the response is stalled, 0 for none
	// called on a falling edge, so the request goes out at once
	task automatic do_read(input int p, input axi_addr_t addr, input int hold);
		axi_r_t exp;
		exp.resp = addr_in_range(addr) ? RESP_OKAY : RESP_SLVERR;
		exp.data = ref_mem[int'(addr[IDX_W+1:2])];
		exp_r_q[p].push_back(exp);
		r_ready[p]  = (hold == 0);
		ar[p].addr  = addr;
		ar_valid[p] = 1'b1;
		do @(negedge clk); while (!ar_done[p]);
		ar_valid[p] = 1'b0;
		if (hold != 0) begin
			while (!r_valid[p]) @(negedge clk);
			repeat (hold) @(negedge clk);
			r_ready[p] = 1'b1;
		end
		while (!r_done[p]) @(negedge clk);
	endtask

	task automatic do_write(input int p, input axi_addr_t addr, input axi_data_t data,
		input axi_strb_t strb, input int hold);
		axi_b_t exp;
		int     idx;
		idx = int'(addr[IDX_W+1:2]);
		if (addr_in_range(addr)) begin
			exp.resp     = RESP_OKAY;
			ref_mem[idx] = merge_bytes(ref_mem[idx], data, strb);
		end else begin
			exp.resp = RESP_SLVERR; // memory untouched
		end
		exp_b_q[p].push_back(exp);
		b_ready[p]  = (hold == 0);
		aw[p].addr  = addr;
		w[p].data   = data;
		w[p].strb   = strb;
		aw_valid[p] = 1'b1;
		w_valid[p]  = 1'b1;
		do @(negedge clk); while (!aw_done[p]);
		aw_valid[p] = 1'b0;
		w_valid[p]  = 1'b0;
		if (hold != 0) begin
			while (!b_valid[p]) @(negedge clk);
			repeat (hold) @(negedge clk);
			b_ready[p] = 1'b1;
		end
		while (!b_done[p]) @(negedge clk);
	endtask

	initial begin
		#(WATCHDOG_NS);
		abort_run("timeout, a transaction did not complete in time");
	end

	initial begin
		int        idx;
		int        idx_hi;
		int        hold;
		axi_addr_t addr;
		axi_data_t data;
		axi_data_t data_hi;
		axi_strb_t strb;

		rstn = 1'b0;
		for (int p = 0; p < 2; p++) begin
			ar[p]       = '0;
			ar_valid[p] = 1'b0;
			aw[p]       = '0;
			aw_valid[p] = 1'b0;
			w[p]        = '0;
			w_valid[p]  = 1'b0;
			r_ready[p]  = 1'b1;
			b_ready[p]  = 1'b1;
			waits[p]    = 0;
		end

		test_name = "reset";
		repeat (5) begin
			@(negedge clk);
			check_idle();
		end
		rstn = 1'b1;
		@(negedge clk);
		check_idle();

		// memory is not reset, so every word gets a known value first
		test_name = "fill";
		for (int i = 0; i < DEPTH; i++) do_write(i % 2, word_addr(i), fill_word(i), 4'hf, 0);

		test_name = "write_read";
		repeat (32) begin
			idx  = $random(seed) & (DEPTH - 1);
			data = $random(seed);
			do_write(0, word_addr(idx), data, 4'hf, 0);
			do_read(1, word_addr(idx) | axi_addr_t'($random(seed) & 3), 0); // low bits ignored
		end

		test_name = "partial_strobe";
		repeat (16) begin
			idx  = $random(seed) & (DEPTH - 1);
			data = $random(seed);
			strb = 4'($random(seed));
			if (strb == 4'h0 || strb == 4'hf) strb = 4'h5;
			do_write(1, word_addr(idx), data, strb, 0);
			do_read(0, word_addr(idx), 0);
		end

		test_name = "out_of_range";
		repeat (8) begin
			idx  = $random(seed) & (DEPTH - 1);
			addr = axi_addr_t'($random(seed));
			addr[IDX_W+1:0] = {8'(idx), 2'b00};
			if (addr_in_range(addr)) addr[`AXI_MEM_ADDR_W-1] = 1'b1;
			do_read(0, addr, 0);
			do_write(1, addr, $random(seed), 4'hf, 0);
			do_read(0, word_addr(idx), 0); // aliased word unchanged
		end

		// fetch port in the lower half, load/store port in the upper half
		test_name = "contention";
		repeat (16) begin
			idx     = $random(seed) & (DEPTH / 2 - 1);
			idx_hi  = DEPTH / 2 + ($random(seed) & (DEPTH / 2 - 1));
			data    = $random(seed);
			data_hi = $random(seed);
			// each port follows its write with a read right away
			fork
				begin
					do_write(0, word_addr(idx), data, 4'hf, 0);
					do_read(0, word_addr(idx), 0);
				end
				begin
					do_write(1, word_addr(idx_hi), data_hi, 4'hf, 0);
					do_read(1, word_addr(idx_hi), 0);
				end
			join
		end

		test_name = "back_pressure";
		repeat (8) begin
			idx  = $random(seed) & (DEPTH - 1);
			hold = 1 + ($random(seed) & 7);
			do_write(idx % 2, word_addr(idx), $random(seed), 4'hf, hold);
			hold = 1 + ($random(seed) & 7);
			do_read(1 - idx % 2, word_addr(idx), hold);
		end

		@(negedge clk);
		if (exp_r_q[0].size() == 0 && exp_r_q[1].size() == 0 &&
			exp_b_q[0].size() == 0 && exp_b_q[1].size() == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			abort_run("expected responses were still outstanding at the end");
		end
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+src
src/axi_mem_pkg.sv
src/lfsr4.sv
src/sram_array.sv
src/axi_sram.sv
src/axi_arbiter.sv
src/axi_mem_top.sv
tb/tb_axi_mem_top.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 -f sim.f --top-module tb_axi_mem_top

# the simulator exits non-zero on failure, the log search decides the result
./obj_dir/Vtb_axi_mem_top > sim.log 2>&1 || true
cat sim.log

if grep -qx "Simulation finished: PASS" sim.log; then
	exit 0
else
	echo "run.sh: pass message not found in sim.log"
	exit 1
fi
